// ==== include/rtos_cfg.svh ====
/* Kernel sizing. RTOS_TASK_NUM must equal 2**RTOS_TSKID_W, and the status map
   at 0x20 leaves room for at most four tasks */
`ifndef RTOS_CFG_SVH
`define RTOS_CFG_SVH

`define RTOS_TASK_NUM  4
`define RTOS_TSKID_W   2
// Lower priority value is more urgent
`define RTOS_TSKPRI_W  4
`define RTOS_FLGPTN_W  8
`define RTOS_RELTIM_W  16
`define RTOS_SEMCNT_W  4
// Clocks per system tick
`define RTOS_TICK_DIV  8
`define RTOS_AXI_AW    8

`endif

// ==== logic/rtos_pkg.sv ====
/* Shared kernel types. The service arg is 16 bits and holds either a delay
   or, in its low byte, a flag pattern */
`include "rtos_cfg.svh"

package rtos_pkg;

    typedef enum logic [3:0] {
        TS_SLEEP  = 4'h0,
        TS_REQRDY = 4'h1,
        TS_READY  = 4'h2,
        TS_DELAY  = 4'h3,
        TS_WAISEM = 4'h4,
        TS_WAIFLG = 4'h5
    } tskstat_t;

    typedef enum logic [3:0] {
        OP_NOP         = 4'h0,
        OP_WUP         = 4'h1,
        OP_SLP         = 4'h2,
        OP_REL_WAI     = 4'h3,
        OP_DLY         = 4'h4,
        OP_WAI_SEM     = 4'h5,
        OP_SIG_SEM     = 4'h6,
        OP_WAI_FLG_AND = 4'h7,
        OP_WAI_FLG_OR  = 4'h8,
        OP_SET_FLG     = 4'h9,
        OP_CLR_FLG     = 4'ha
    } svc_op_t;

    typedef struct packed {
        logic                     valid;
        svc_op_t                  op;
        logic [`RTOS_TSKID_W-1:0] tskid;
        logic [15:0]              arg;
    } svc_req_t;

    typedef struct packed {
        logic                      rdy;
        logic                      rel;
        logic                      wup;
        logic                      slp;
        logic                      rel_wai;
        logic                      dly;
        logic                      wai_sem;
        logic                      wai_flg;
        logic [`RTOS_RELTIM_W-1:0] dlytim;
        // 0 waits for all pattern bits, 1 for any of them
        logic                      wfmode;
        logic [`RTOS_FLGPTN_W-1:0] flgptn;
    } task_cmd_t;

    typedef struct packed {
        tskstat_t                  tskstat;
        logic [`RTOS_TSKPRI_W-1:0] tskpri;
        logic                      req_rdq;
    } task_status_t;

    // Lowest priority value among the masked tasks, lower id wins a tie
    // The MSB of the result flags that some task was found
    function automatic logic [`RTOS_TSKID_W:0] pick_best(
        input logic [`RTOS_TASK_NUM-1:0]                     mask,
        input logic [`RTOS_TASK_NUM-1:0][`RTOS_TSKPRI_W-1:0] pri
    );
        logic                     found;
        logic [`RTOS_TSKID_W-1:0] id;
        found = 1'b0;
        id    = '0;
        for (int i = 0; i < `RTOS_TASK_NUM; i++) begin
            if (mask[i] && (!found || pri[i] < pri[id])) begin
                found = 1'b1;
                id    = i[`RTOS_TSKID_W-1:0];
            end
        end
        return {found, id};
    endfunction

endpackage

// ==== logic/rtos_axil_regs.sv ====
/* AXI4-Lite slave, one outstanding write and one outstanding read. Only
   word-aligned mapped addresses answer OKAY, the rest get SLVERR */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_axil_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`RTOS_AXI_AW-1:0]       awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic                          bvalid,
    output logic [1:0]                    bresp,
    input  logic                          bready,
    input  logic [`RTOS_AXI_AW-1:0]       araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic                          rvalid,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    input  logic                          rready,
    output rtos_pkg::svc_req_t            svc_req,
    input  rtos_pkg::task_status_t        task_status [`RTOS_TASK_NUM],
    input  logic                          run_valid,
    input  logic [`RTOS_TSKID_W-1:0]      run_id,
    input  logic [`RTOS_FLGPTN_W-1:0]     flgptn,
    input  logic [`RTOS_SEMCNT_W-1:0]     semcnt
);
    import rtos_pkg::*;

    localparam logic [`RTOS_AXI_AW-1:0] ADR_SVC    = 'h00;
    localparam logic [`RTOS_AXI_AW-1:0] ADR_ARG    = 'h04;
    localparam logic [`RTOS_AXI_AW-1:0] ADR_RUN    = 'h08;
    localparam logic [`RTOS_AXI_AW-1:0] ADR_FLAG   = 'h0c;
    localparam logic [`RTOS_AXI_AW-1:0] ADR_SEMCNT = 'h10;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] arg_q;
    logic [31:0] rd_data;
    logic        wr_fire;
    logic        rd_fire;

    // Task status words sit at 0x20 + 4*id
    function automatic logic is_mapped(input logic [`RTOS_AXI_AW-1:0] a);
        return a == ADR_SVC || a == ADR_ARG || a == ADR_RUN || a == ADR_FLAG
            || a == ADR_SEMCNT || (a[`RTOS_AXI_AW-1:4] == 'h2 && a[1:0] == 2'b00);
    endfunction

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    always_comb begin
        rd_data = '0;
        case (araddr)
            ADR_ARG:    rd_data = arg_q;
            ADR_RUN:    rd_data = {23'b0, run_valid, 6'b0, run_id};
            ADR_FLAG:   rd_data = 32'(flgptn);
            ADR_SEMCNT: rd_data = 32'(semcnt);
            default: begin
                if (is_mapped(araddr) && araddr[`RTOS_AXI_AW-1:4] == 'h2) begin
                    rd_data[3:0] = task_status[araddr[2 +: `RTOS_TSKID_W]].tskstat;
                    rd_data[7:4] = task_status[araddr[2 +: `RTOS_TSKID_W]].tskpri;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
            svc_req <= '0;
            arg_q   <= '0;
        end else begin
            // Ready is a one-cycle pulse, raised only while no response is pending
            awready       <= awvalid && wvalid && !bvalid && !awready;
            wready        <= awvalid && wvalid && !bvalid && !awready;
            arready       <= arvalid && !rvalid && !arready;
            svc_req.valid <= 1'b0;

            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
                if (awaddr == ADR_SVC) begin
                    svc_req.valid <= 1'b1;
                    svc_req.op    <= svc_op_t'(wdata[3:0]);
                    svc_req.tskid <= wdata[4 +: `RTOS_TSKID_W];
                    svc_req.arg   <= arg_q[15:0];
                end
                if (awaddr == ADR_ARG) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            arg_q[8*b +: 8] <= wdata[8*b +: 8];
                        end
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_data;
                rresp  <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // A pending response keeps its code until the host takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

    a_svc_pulse: assert property (@(posedge clk) disable iff (reset)
        svc_req.valid |=> !svc_req.valid)
        else $error("svc_req.valid held longer than one cycle");

endmodule

// ==== logic/rtos_task_fsm.sv ====
/* Task control block. Priority is fixed at INIT_TSKPRI; rdy beats every other
   strobe, and the remaining strobes are expected one at a time */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_task_fsm #(
    parameter logic [`RTOS_TSKID_W-1:0]  TSKID       = '0,
    parameter logic [`RTOS_TSKPRI_W-1:0] INIT_TSKPRI = TSKID
) (
    input  logic                      clk,
    input  logic                      reset,
    input  rtos_pkg::task_cmd_t       cmd,
    input  logic                      tick,
    input  logic [`RTOS_FLGPTN_W-1:0] flgptn,
    output rtos_pkg::task_status_t    status
);
    import rtos_pkg::*;

    tskstat_t                  tskstat;
    tskstat_t                  next_tskstat;
    logic [`RTOS_TSKPRI_W-1:0] tskpri;
    logic                      req_rdq;
    logic                      wfmode;
    logic [`RTOS_FLGPTN_W-1:0] wait_ptn;
    logic [`RTOS_RELTIM_W-1:0] dlytim;
    logic                      flg_met;

    // OR mode needs any stored bit, AND mode needs all of them
    assign flg_met = wfmode ? |(flgptn & wait_ptn) : ((flgptn & wait_ptn) == wait_ptn);

    always_comb begin
        next_tskstat = tskstat;
        if (cmd.rdy) begin
            next_tskstat = TS_READY;
        end else if (cmd.rel || cmd.wup || cmd.rel_wai) begin
            next_tskstat = TS_REQRDY;
        end else if (cmd.slp) begin
            next_tskstat = TS_SLEEP;
        end else if (cmd.dly) begin
            next_tskstat = TS_DELAY;
        end else if (cmd.wai_sem) begin
            next_tskstat = TS_WAISEM;
        end else if (cmd.wai_flg) begin
            next_tskstat = TS_WAIFLG;
        end else if (tskstat == TS_WAIFLG && flg_met) begin
            next_tskstat = TS_REQRDY;
        end else if (tskstat == TS_DELAY && dlytim == '0) begin
            next_tskstat = TS_REQRDY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tskstat <= TS_SLEEP;
            req_rdq <= 1'b0;
            tskpri  <= INIT_TSKPRI;
            dlytim  <= '0;
        end else begin
            tskstat <= next_tskstat;
            req_rdq <= (next_tskstat == TS_REQRDY);
            if (cmd.dly) begin
                dlytim <= cmd.dlytim;
            end else if (tick && dlytim != '0) begin
                dlytim <= dlytim - 1'b1;
            end
        end
    end

    // Wait condition is captured with the wait call itself
    always_ff @(posedge clk) begin
        if (cmd.wai_flg) begin
            wfmode   <= cmd.wfmode;
            wait_ptn <= cmd.flgptn;
        end
    end

    assign status = '{tskstat: tskstat, tskpri: tskpri, req_rdq: req_rdq};

    // Sync and scheduler strobes must never collide on one task
    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cmd.rel, cmd.wup, cmd.slp, cmd.rel_wai, cmd.dly, cmd.wai_sem, cmd.wai_flg}))
        else $error("task %0d received more than one command strobe", TSKID);

endmodule

// ==== logic/rtos_tick_timer.sv ====
/* System tick prescaler. tick is high for one clock every RTOS_TICK_DIV clocks */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_tick_timer (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    localparam int CNT_W = $clog2(`RTOS_TICK_DIV);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == CNT_W'(`RTOS_TICK_DIV - 1));
            if (cnt == CNT_W'(`RTOS_TICK_DIV - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/rtos_scheduler.sv ====
/* Priority scheduler. Dispatch lands one cycle after req_rdq, and preemption
   only happens for a strictly better priority */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_scheduler (
    input  logic                         clk,
    input  logic                         reset,
    input  rtos_pkg::task_status_t       task_status [`RTOS_TASK_NUM],
    output logic [`RTOS_TASK_NUM-1:0]    rdy,
    output logic [`RTOS_TASK_NUM-1:0]    rel,
    output logic                         run_valid,
    output logic [`RTOS_TSKID_W-1:0]     run_id
);
    import rtos_pkg::*;

    logic [`RTOS_TASK_NUM-1:0]                     rdq_mask;
    logic [`RTOS_TASK_NUM-1:0][`RTOS_TSKPRI_W-1:0] pri_vec;
    logic [`RTOS_TSKID_W:0]                        pick;
    logic [`RTOS_TSKID_W-1:0]                      pick_id;
    logic                                          run_ok;

    always_comb begin
        for (int i = 0; i < `RTOS_TASK_NUM; i++) begin
            rdq_mask[i] = task_status[i].req_rdq;
            pri_vec[i]  = task_status[i].tskpri;
        end
    end

    assign pick    = pick_best(rdq_mask, pri_vec);
    assign pick_id = pick[`RTOS_TSKID_W-1:0];
    // The reported task only counts while it still sits in TS_READY
    assign run_ok  = run_valid && task_status[run_id].tskstat == TS_READY;

    always_comb begin
        rdy = '0;
        rel = '0;
        if (pick[`RTOS_TSKID_W]) begin
            if (!run_ok) begin
                rdy[pick_id] = 1'b1;
            end else if (pri_vec[pick_id] < pri_vec[run_id]) begin
                rel[run_id]  = 1'b1;
                rdy[pick_id] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_valid <= 1'b0;
            run_id    <= '0;
        end else if (|rdy) begin
            run_valid <= 1'b1;
            run_id    <= pick_id;
        end else if (!run_ok) begin
            run_valid <= 1'b0;
        end
    end

    // Dispatch goes to one task at most, and only to a task that asked for it
    a_rdy_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rdy) && (rdy & ~rdq_mask) == '0)
        else $error("rdy not one-hot or sent to a task without req_rdq: %h", rdy);

endmodule

// ==== logic/rtos_sync.sv ====
/* Semaphore and event flag. Waits have no timeout; the semaphore count
   saturates at its maximum */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_sync (
    input  logic                         clk,
    input  logic                         reset,
    input  rtos_pkg::svc_req_t           svc_req,
    input  rtos_pkg::task_status_t       task_status [`RTOS_TASK_NUM],
    output rtos_pkg::task_cmd_t          cmd [`RTOS_TASK_NUM],
    output logic [`RTOS_FLGPTN_W-1:0]    flgptn,
    output logic [`RTOS_SEMCNT_W-1:0]    semcnt
);
    import rtos_pkg::*;

    logic [`RTOS_TASK_NUM-1:0]                     sem_mask;
    logic [`RTOS_TASK_NUM-1:0][`RTOS_TSKPRI_W-1:0] pri_vec;
    logic [`RTOS_TSKID_W:0]                        waiter;

    always_comb begin
        for (int i = 0; i < `RTOS_TASK_NUM; i++) begin
            sem_mask[i] = (task_status[i].tskstat == TS_WAISEM);
            pri_vec[i]  = task_status[i].tskpri;
        end
    end

    // Best task currently blocked on the semaphore
    assign waiter = pick_best(sem_mask, pri_vec);

    always_comb begin
        for (int i = 0; i < `RTOS_TASK_NUM; i++) begin
            cmd[i]        = '0;
            cmd[i].dlytim = svc_req.arg[`RTOS_RELTIM_W-1:0];
            cmd[i].wfmode = (svc_req.op == OP_WAI_FLG_OR);
            cmd[i].flgptn = svc_req.arg[`RTOS_FLGPTN_W-1:0];
        end
        if (svc_req.valid) begin
            case (svc_req.op)
                OP_WUP:     cmd[svc_req.tskid].wup     = 1'b1;
                OP_SLP:     cmd[svc_req.tskid].slp     = 1'b1;
                OP_REL_WAI: cmd[svc_req.tskid].rel_wai = 1'b1;
                OP_DLY:     cmd[svc_req.tskid].dly     = 1'b1;
                OP_WAI_SEM: cmd[svc_req.tskid].wai_sem = (semcnt == '0);
                OP_SIG_SEM: begin
                    if (waiter[`RTOS_TSKID_W]) begin
                        cmd[waiter[`RTOS_TSKID_W-1:0]].rel_wai = 1'b1;
                    end
                end
                OP_WAI_FLG_AND, OP_WAI_FLG_OR: cmd[svc_req.tskid].wai_flg = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flgptn <= '0;
            semcnt <= '0;
        end else if (svc_req.valid) begin
            case (svc_req.op)
                OP_WAI_SEM: begin
                    if (semcnt != '0) begin
                        semcnt <= semcnt - 1'b1;
                    end
                end
                OP_SIG_SEM: begin
                    if (!waiter[`RTOS_TSKID_W] && semcnt != '1) begin
                        semcnt <= semcnt + 1'b1;
                    end
                end
                OP_SET_FLG: flgptn <= flgptn | svc_req.arg[`RTOS_FLGPTN_W-1:0];
                OP_CLR_FLG: flgptn <= flgptn & svc_req.arg[`RTOS_FLGPTN_W-1:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/rtos_core.sv ====
/* Kernel top. Register writes at 0x00 issue service calls; task status is
   polled through the read-only registers */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`RTOS_AXI_AW-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    output logic [1:0]              bresp,
    input  logic                    bready,
    input  logic [`RTOS_AXI_AW-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    input  logic                    rready
);
    import rtos_pkg::*;

    svc_req_t                  svc_req;
    task_status_t              task_status [`RTOS_TASK_NUM];
    task_cmd_t                 sync_cmd [`RTOS_TASK_NUM];
    logic [`RTOS_TASK_NUM-1:0] sched_rdy;
    logic [`RTOS_TASK_NUM-1:0] sched_rel;
    logic                      run_valid;
    logic [`RTOS_TSKID_W-1:0]  run_id;
    logic [`RTOS_FLGPTN_W-1:0] flgptn;
    logic [`RTOS_SEMCNT_W-1:0] semcnt;
    logic                      tick;

    rtos_axil_regs u_regs (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
        .svc_req, .task_status, .run_valid, .run_id, .flgptn, .semcnt
    );

    rtos_tick_timer u_tick (.clk, .reset, .tick);

    rtos_scheduler u_sched (
        .clk, .reset, .task_status,
        .rdy (sched_rdy),
        .rel (sched_rel),
        .run_valid, .run_id
    );

    rtos_sync u_sync (.clk, .reset, .svc_req, .task_status, .cmd (sync_cmd), .flgptn, .semcnt);

    for (genvar i = 0; i < `RTOS_TASK_NUM; i++) begin : g_task
        task_cmd_t tcmd;

        // Scheduler strobes merge into the service commands for this task
        always_comb begin
            tcmd     = sync_cmd[i];
            tcmd.rdy = sync_cmd[i].rdy | sched_rdy[i];
            tcmd.rel = sync_cmd[i].rel | sched_rel[i];
        end

        rtos_task_fsm #(
            .TSKID       (i),
            .INIT_TSKPRI (i)
        ) u_task (
            .clk, .reset,
            .cmd    (tcmd),
            .tick,
            .flgptn,
            .status (task_status[i])
        );
    end

endmodule

// ==== verif/rtos_core_tb.sv ====
/* Testbench for rtos_core. Results come from polled status reads, so timing
   checks use coarse cycle bounds only */
`timescale 1ns/1ps
`include "rtos_cfg.svh"

module rtos_core_tb;
    import rtos_pkg::*;

    // The full run needs well under 1000 cycles, so this limit leaves a wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int DIV        = `RTOS_TICK_DIV;
    localparam int POLLS      = 16;
    localparam logic [7:0] ADR_SVC    = 8'h00;
    localparam logic [7:0] ADR_ARG    = 8'h04;
    localparam logic [7:0] ADR_RUN    = 8'h08;
    localparam logic [7:0] ADR_FLAG   = 8'h0c;
    localparam logic [7:0] ADR_SEMCNT = 8'h10;
    localparam logic [7:0] ADR_STAT   = 8'h20;

    logic                    clk;
    logic                    reset;
    logic [`RTOS_AXI_AW-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic                    bvalid;
    logic [1:0]              bresp;
    logic                    bready;
    logic [`RTOS_AXI_AW-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic                    rvalid;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rready;

    // One pending check, raised by the stimulus and judged by the assertion below
    logic        chk_en;
    logic        chk_plain;
    logic [31:0] chk_got;
    logic [31:0] chk_exp;
    string       chk_name;

    int          cycle_cnt = 0;
    int          err_cnt;
    int          err_base;
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] word;
    logic [1:0]  resp;
    logic [7:0]  flag_model;
    logic [7:0]  ptn;
    logic [7:0]  mask;
    int          bit_a;
    int          bit_b;
    int          t0;
    int          elapsed;

    rtos_core u_rtos_core (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    a_result: assert property (@(posedge clk) chk_en |-> chk_got == chk_exp)
        else begin
            err_cnt = err_cnt + 1;
            if (chk_plain) begin
                $display("%s", chk_name);
            end else begin
                $display("Fail %s: got %h, expected %h", chk_name, chk_got, chk_exp);
            end
        end

    // Every response must follow its ready pulse, and awready pairs with wready
    a_wr_handshake: assert property (@(posedge clk) disable iff (reset)
        $rose(bvalid) |-> $past(awready && wready))
        else begin
            err_cnt = err_cnt + 1;
            $display("bvalid rose without an awready and wready pulse the cycle before");
        end

    a_wr_ready_pair: assert property (@(posedge clk) disable iff (reset) awready == wready)
        else begin
            err_cnt = err_cnt + 1;
            $display("Fail wready: got %h, expected %h", wready, awready);
        end

    a_rd_handshake: assert property (@(posedge clk) disable iff (reset)
        $rose(rvalid) |-> $past(arready))
        else begin
            err_cnt = err_cnt + 1;
            $display("rvalid rose without an arready pulse the cycle before");
        end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Holds the check for one edge so the assertion samples it
    task automatic post_check(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input logic plain);
        chk_name  = name;
        chk_got   = got;
        chk_exp   = exp;
        chk_plain = plain;
        chk_en    = 1'b1;
        @(posedge clk);
        #1;
        chk_en    = 1'b0;
    endtask

    // bready stays low for one cycle after bvalid, so the response has to wait
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] bresp_out);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!bvalid);
        bresp_out = bresp;
        awvalid   = 1'b0;
        wvalid    = 1'b0;
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] rresp_out);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!rvalid);
        data      = rdata;
        rresp_out = rresp;
        arvalid   = 1'b0;
    endtask

    task automatic issue_svc(input svc_op_t op, input logic [1:0] id, input logic [15:0] arg);
        logic [1:0] r;
        axi_write(ADR_ARG, {16'b0, arg}, r);
        axi_write(ADR_SVC, {26'b0, id, op}, r);
    endtask

    // Polls a register until it shows the expected value, then checks the last read
    task automatic verify_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] d;
        logic [1:0]  r;
        for (int n = 0; n < POLLS; n++) begin
            axi_read(addr, d, r);
            if (d == exp) break;
        end
        post_check(name, d, exp, 1'b0);
    endtask

    // Status word holds the priority in bits 7:4, and priority equals the id
    task automatic verify_task(input logic [1:0] id, input tskstat_t want);
        verify_reg($sformatf("task%0d status", id), ADR_STAT + 8'(4 * id),
                   {24'b0, 2'b0, id, want});
    endtask

    task automatic report_test(input string name);
        if (err_cnt == err_base) begin
            pass_cnt = pass_cnt + 1;
            $display("%-12s pass", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("%-12s FAIL (%0d errors)", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    initial begin
        void'($urandom(15));
        reset     = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        chk_en    = 1'b0;
        chk_plain = 1'b0;
        chk_got   = '0;
        chk_exp   = '0;
        err_cnt   = 0;
        err_base  = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < `RTOS_TASK_NUM; i++) verify_task(2'(i), TS_SLEEP);
        verify_reg("RUN", ADR_RUN, 32'h0);
        verify_reg("FLAG", ADR_FLAG, 32'h0);
        verify_reg("SEMCNT", ADR_SEMCNT, 32'h0);
        report_test("reset");

        issue_svc(OP_WUP, 2'd2, 16'h0);
        verify_reg("RUN", ADR_RUN, 32'h102);
        issue_svc(OP_WUP, 2'd3, 16'h0);
        verify_task(2'd3, TS_REQRDY);
        verify_reg("RUN", ADR_RUN, 32'h102);
        issue_svc(OP_WUP, 2'd0, 16'h0);
        verify_reg("RUN", ADR_RUN, 32'h100);
        verify_task(2'd2, TS_REQRDY);
        issue_svc(OP_SLP, 2'd0, 16'h0);
        verify_reg("RUN", ADR_RUN, 32'h102);
        report_test("dispatch");

        // Five ticks cannot finish in fewer than four tick periods
        issue_svc(OP_DLY, 2'd1, 16'd5);
        t0 = cycle_cnt;
        axi_read(ADR_STAT + 8'd4, word, resp);
        post_check("task1 status", word, {24'b0, 4'd1, TS_DELAY}, 1'b0);
        do begin
            axi_read(ADR_STAT + 8'd4, word, resp);
        end while (word[3:0] == TS_DELAY && cycle_cnt - t0 < 7 * DIV + 20);
        elapsed = cycle_cnt - t0;
        post_check($sformatf("Task 1 left its delay after only %0d cycles", elapsed),
                   32'(elapsed >= 4 * DIV), 32'h1, 1'b1);
        post_check($sformatf("Task 1 was not ready %0d cycles after its delay call", elapsed),
                   32'((word[3:0] == TS_REQRDY || word[3:0] == TS_READY)
                       && elapsed <= 7 * DIV + 10), 32'h1, 1'b1);
        report_test("delay");

        issue_svc(OP_SIG_SEM, 2'd0, 16'h0);
        issue_svc(OP_SIG_SEM, 2'd0, 16'h0);
        verify_reg("SEMCNT", ADR_SEMCNT, 32'h2);
        issue_svc(OP_WAI_SEM, 2'd3, 16'h0);
        verify_task(2'd3, TS_REQRDY);
        verify_reg("SEMCNT", ADR_SEMCNT, 32'h1);
        issue_svc(OP_WAI_SEM, 2'd3, 16'h0);
        verify_task(2'd3, TS_REQRDY);
        verify_reg("SEMCNT", ADR_SEMCNT, 32'h0);
        issue_svc(OP_WAI_SEM, 2'd3, 16'h0);
        verify_task(2'd3, TS_WAISEM);
        issue_svc(OP_SIG_SEM, 2'd0, 16'h0);
        verify_task(2'd3, TS_REQRDY);
        verify_reg("SEMCNT", ADR_SEMCNT, 32'h0);
        report_test("semaphore");

        // Two distinct random bits for the AND wait
        bit_a = $urandom % 8;
        bit_b = (bit_a + 1 + $urandom % 7) % 8;
        ptn   = 8'(1 << bit_a) | 8'(1 << bit_b);
        issue_svc(OP_WAI_FLG_AND, 2'd3, {8'b0, ptn});
        verify_task(2'd3, TS_WAIFLG);
        flag_model = 8'(1 << bit_a);
        issue_svc(OP_SET_FLG, 2'd0, {8'b0, flag_model});
        verify_reg("FLAG", ADR_FLAG, {24'b0, flag_model});
        verify_task(2'd3, TS_WAIFLG);
        flag_model = flag_model | 8'(1 << bit_b);
        issue_svc(OP_SET_FLG, 2'd0, {8'b0, 8'(1 << bit_b)});
        verify_task(2'd3, TS_REQRDY);
        issue_svc(OP_CLR_FLG, 2'd0, 16'h0);
        flag_model = 8'h0;
        verify_reg("FLAG", ADR_FLAG, 32'h0);
        bit_a = $urandom % 8;
        bit_b = (bit_a + 1 + $urandom % 7) % 8;
        ptn   = 8'(1 << bit_a) | 8'(1 << bit_b);
        issue_svc(OP_WAI_FLG_OR, 2'd3, {8'b0, ptn});
        verify_task(2'd3, TS_WAIFLG);
        flag_model = 8'(1 << bit_b);
        issue_svc(OP_SET_FLG, 2'd0, {8'b0, flag_model});
        verify_task(2'd3, TS_REQRDY);
        ptn  = 8'($urandom);
        mask = 8'($urandom);
        flag_model = flag_model | ptn;
        issue_svc(OP_SET_FLG, 2'd0, {8'b0, ptn});
        verify_reg("FLAG", ADR_FLAG, {24'b0, flag_model});
        flag_model = flag_model & mask;
        issue_svc(OP_CLR_FLG, 2'd0, {8'b0, mask});
        verify_reg("FLAG", ADR_FLAG, {24'b0, flag_model});
        report_test("event flag");

        axi_read(8'h14, word, resp);
        post_check("rresp", {30'b0, resp}, 32'h2, 1'b0);
        // A wake of sleeping task 0 would preempt task 1 if the bad write leaked through
        axi_write(8'h18, {26'b0, 2'd0, OP_WUP}, resp);
        post_check("bresp", {30'b0, resp}, 32'h2, 1'b0);
        verify_task(2'd0, TS_SLEEP);
        verify_task(2'd1, TS_READY);
        verify_task(2'd2, TS_REQRDY);
        verify_task(2'd3, TS_REQRDY);
        verify_reg("RUN", ADR_RUN, 32'h101);
        report_test("bus error");

        $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
logic/rtos_pkg.sv
logic/rtos_axil_regs.sv
logic/rtos_task_fsm.sv
logic/rtos_tick_timer.sv
logic/rtos_scheduler.sv
logic/rtos_sync.sv
logic/rtos_core.sv
verif/rtos_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the RTOS kernel testbench

VERILATOR ?= verilator
TOP       ?= rtos_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
